// File: common/trace_pkg.sv
`default_nettype none

package trace_pkg;

  ////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////

  localparam int unsigned CYCLE_W = 32;

  typedef logic [31:0]        word_t;
  typedef logic [4:0]         reg_idx_t;
  typedef logic [CYCLE_W-1:0] cycle_t;

  ////////////////////////////////////////
  // rv32i major opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;

  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_op_imm,
    cls_op,
    cls_system,
    cls_fence,
    cls_invalid
  } instr_class_e;

  ////////////////////////////////////////
  // records
  ////////////////////////////////////////

  // built at decode
  typedef struct packed {
    word_t        pc;
    word_t        instr;
    cycle_t       cycle;
    instr_class_e cls;
    reg_idx_t     rd;
    logic         writes_rd;
  } issue_rec_t;

  // finished record, after EX and WB
  typedef struct packed {
    issue_rec_t issue;
    logic       rd_written;
    word_t      rd_value;
    logic       mem_valid;
    logic       mem_we;
    word_t      mem_addr;
  } trace_rec_t;

  typedef struct packed {
    logic     we;
    reg_idx_t addr;
    word_t    wdata;
  } reg_wr_t;

endpackage

`default_nettype wire

// File: hw/trace_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module trace_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic push,
  input  wire T     push_data,
  input  wire logic pop,
  output T          head,
  output logic      not_empty,
  output logic      full
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  // push while full is dropped, pusher checks full
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  assign full      = (count == (PTR_W+1)'(DEPTH));
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr == PTR_W'(DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr == PTR_W'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/issue_capture.sv
`default_nettype none
`timescale 1ns/1ps

module issue_capture (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             id_valid,
  input  wire logic             is_decoding,
  input  wire trace_pkg::word_t pc,
  input  wire trace_pkg::word_t instr,
  input  wire logic             q_full,
  output logic                  push,
  output trace_pkg::issue_rec_t rec,
  output logic                  issue_overflow
);

  import trace_pkg::*;

  cycle_t       cycle_cnt;
  logic         issue;
  instr_class_e cls;
  reg_idx_t     rd;
  logic         cls_writes;

  ////////////////////////////////////////
  // free-running cycle stamp
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // classify by major opcode
  ////////////////////////////////////////

  always_comb begin
    case (instr[6:0])
      OPC_LUI:    cls = cls_lui;
      OPC_AUIPC:  cls = cls_auipc;
      OPC_JAL:    cls = cls_jal;
      OPC_JALR:   cls = cls_jalr;
      OPC_BRANCH: cls = cls_branch;
      OPC_LOAD:   cls = cls_load;
      OPC_STORE:  cls = cls_store;
      OPC_OP_IMM: cls = cls_op_imm;
      OPC_OP:     cls = cls_op;
      OPC_SYSTEM: cls = cls_system;
      OPC_FENCE:  cls = cls_fence;
      default:    cls = cls_invalid;
    endcase
  end

  // classes that may write rd
  always_comb begin
    case (cls)
      cls_lui, cls_auipc, cls_jal, cls_jalr,
      cls_load, cls_op_imm, cls_op, cls_system: cls_writes = 1'b1;
      default:                                  cls_writes = 1'b0;
    endcase
  end

  assign rd = instr[11:7];

  // x0 is never a real destination
  assign rec.pc        = pc;
  assign rec.instr     = instr;
  assign rec.cycle     = cycle_cnt;
  assign rec.cls       = cls;
  assign rec.rd        = rd;
  assign rec.writes_rd = cls_writes && (rd != '0);

  ////////////////////////////////////////
  // push into the issue queue
  ////////////////////////////////////////

  assign issue = id_valid && is_decoding;
  assign push  = issue && !q_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_overflow <= 1'b0;
    end else if (issue && q_full) begin
      issue_overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: stage_track/ex_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module ex_tracker (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire trace_pkg::issue_rec_t head,
  input  wire logic                  head_valid,
  output logic                       pop,
  input  wire logic                  ex_valid,
  input  wire logic                  wb_bypass,
  input  wire trace_pkg::reg_wr_t    ex_wr,
  input  wire logic                  ex_data_req,
  input  wire logic                  ex_data_gnt,
  input  wire logic                  ex_data_we,
  input  wire trace_pkg::word_t      ex_data_addr,
  input  wire logic                  out_full,
  output logic                       push,
  output trace_pkg::trace_rec_t      out_rec,
  output logic                       ex_overflow
);

  import trace_pkg::*;

  logic  advance;
  logic  wr_match;
  logic  acc_now;
  // accumulated while the head waits
  logic  rd_hit;
  word_t rd_val;
  logic  mem_hit;
  logic  mem_we_q;
  word_t mem_addr_q;

  assign wr_match = head.writes_rd && ex_wr.we && (ex_wr.addr == head.rd);
  assign acc_now  = ex_data_req && ex_data_gnt;

  // branches leave through wb_bypass
  assign advance = head_valid && (ex_valid || wb_bypass);
  assign pop     = advance;
  assign push    = advance && !out_full;

  // same-cycle strobes win over the stored ones, except for the first access
  assign out_rec.issue      = head;
  assign out_rec.rd_written = rd_hit || wr_match;
  assign out_rec.rd_value   = wr_match ? ex_wr.wdata : rd_val;
  assign out_rec.mem_valid  = mem_hit || acc_now;
  assign out_rec.mem_we     = mem_hit ? mem_we_q : ex_data_we;
  assign out_rec.mem_addr   = mem_hit ? mem_addr_q : ex_data_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_hit      <= 1'b0;
      mem_hit     <= 1'b0;
      ex_overflow <= 1'b0;
    end else begin
      if (advance || !head_valid) begin
        rd_hit  <= 1'b0;
        mem_hit <= 1'b0;
      end else begin
        if (wr_match) begin
          rd_hit <= 1'b1;
        end
        if (acc_now) begin
          mem_hit <= 1'b1;
        end
      end
      if (advance && out_full) begin
        ex_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_match) begin
      rd_val <= ex_wr.wdata;
    end
    // keep only the first granted access
    if (acc_now && !mem_hit) begin
      mem_we_q   <= ex_data_we;
      mem_addr_q <= ex_data_addr;
    end
  end

endmodule

`default_nettype wire

// File: stage_track/wb_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module wb_tracker (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire trace_pkg::trace_rec_t head,
  input  wire logic                  head_valid,
  output logic                       pop,
  input  wire logic                  wb_valid,
  input  wire trace_pkg::reg_wr_t    wb_wr,
  output logic                       trace_valid,
  output trace_pkg::trace_rec_t      trace
);

  import trace_pkg::*;

  logic       retire;
  logic       wr_match;
  logic       wb_hit;
  word_t      wb_val;
  trace_rec_t merged;

  assign wr_match = head.issue.writes_rd && wb_wr.we && (wb_wr.addr == head.issue.rd);
  assign retire   = head_valid && wb_valid;
  assign pop      = retire;

  // wb value overrides whatever EX saw
  always_comb begin
    merged            = head;
    merged.rd_written = head.rd_written || wb_hit || wr_match;
    if (wr_match) begin
      merged.rd_value = wb_wr.wdata;
    end else if (wb_hit) begin
      merged.rd_value = wb_val;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_hit      <= 1'b0;
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= retire;
      if (retire || !head_valid) begin
        wb_hit <= 1'b0;
      end else if (wr_match) begin
        wb_hit <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_match) begin
      wb_val <= wb_wr.wdata;
    end
    if (retire) begin
      trace <= merged;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_trace_unit.sv
`default_nettype none
`timescale 1ns/1ps

module rv_trace_unit #(
  parameter int unsigned ISSUE_DEPTH = 4,
  parameter int unsigned WB_DEPTH    = 2
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // decode
  input  wire logic                id_valid,
  input  wire logic                is_decoding,
  input  wire trace_pkg::word_t    pc,
  input  wire trace_pkg::word_t    instr,
  // execute
  input  wire logic                ex_valid,
  input  wire logic                wb_bypass,
  input  wire logic                ex_reg_we,
  input  wire trace_pkg::reg_idx_t ex_reg_addr,
  input  wire trace_pkg::word_t    ex_reg_wdata,
  input  wire logic                ex_data_req,
  input  wire logic                ex_data_gnt,
  input  wire logic                ex_data_we,
  input  wire trace_pkg::word_t    ex_data_addr,
  // writeback
  input  wire logic                wb_valid,
  input  wire logic                wb_reg_we,
  input  wire trace_pkg::reg_idx_t wb_reg_addr,
  input  wire trace_pkg::word_t    wb_reg_wdata,
  // trace out
  output logic                     trace_valid,
  output trace_pkg::trace_rec_t    trace,
  output logic                     issue_overflow,
  output logic                     ex_overflow
);

  import trace_pkg::*;

  logic       iq_push;
  issue_rec_t iq_data;
  issue_rec_t iq_head;
  logic       iq_not_empty;
  logic       iq_full;
  logic       iq_pop;

  logic       wq_push;
  trace_rec_t wq_data;
  trace_rec_t wq_head;
  logic       wq_not_empty;
  logic       wq_full;
  logic       wq_pop;

  reg_wr_t    ex_wr;
  reg_wr_t    wb_wr;

  assign ex_wr = '{we: ex_reg_we, addr: ex_reg_addr, wdata: ex_reg_wdata};
  assign wb_wr = '{we: wb_reg_we, addr: wb_reg_addr, wdata: wb_reg_wdata};

  ////////////////////////////////////////
  // issue
  ////////////////////////////////////////

  issue_capture issue_capture_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid       (id_valid),
    .is_decoding    (is_decoding),
    .pc             (pc),
    .instr          (instr),
    .q_full         (iq_full),
    .push           (iq_push),
    .rec            (iq_data),
    .issue_overflow (issue_overflow)
  );

  trace_fifo #(
    .T     (issue_rec_t),
    .DEPTH (ISSUE_DEPTH)
  ) issue_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (iq_push),
    .push_data (iq_data),
    .pop       (iq_pop),
    .head      (iq_head),
    .not_empty (iq_not_empty),
    .full      (iq_full)
  );

  ////////////////////////////////////////
  // virtual EX stage
  ////////////////////////////////////////

  ex_tracker ex_tracker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .head         (iq_head),
    .head_valid   (iq_not_empty),
    .pop          (iq_pop),
    .ex_valid     (ex_valid),
    .wb_bypass    (wb_bypass),
    .ex_wr        (ex_wr),
    .ex_data_req  (ex_data_req),
    .ex_data_gnt  (ex_data_gnt),
    .ex_data_we   (ex_data_we),
    .ex_data_addr (ex_data_addr),
    .out_full     (wq_full),
    .push         (wq_push),
    .out_rec      (wq_data),
    .ex_overflow  (ex_overflow)
  );

  trace_fifo #(
    .T     (trace_rec_t),
    .DEPTH (WB_DEPTH)
  ) wb_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (wq_push),
    .push_data (wq_data),
    .pop       (wq_pop),
    .head      (wq_head),
    .not_empty (wq_not_empty),
    .full      (wq_full)
  );

  ////////////////////////////////////////
  // virtual WB stage and output
  ////////////////////////////////////////

  wb_tracker wb_tracker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .head        (wq_head),
    .head_valid  (wq_not_empty),
    .pop         (wq_pop),
    .wb_valid    (wb_valid),
    .wb_wr       (wb_wr),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

endmodule

`default_nettype wire

// File: testbench/tb_rv_trace_unit.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rv_trace_unit;

  import trace_pkg::*;

  localparam int unsigned ISSUE_DEPTH = 4;
  localparam int unsigned WB_DEPTH    = 2;
  localparam int unsigned TIMEOUT     = 50;

  logic       clk;
  logic       rst_n;
  logic       id_valid;
  logic       is_decoding;
  word_t      pc;
  word_t      instr;
  logic       ex_valid;
  logic       wb_bypass;
  logic       ex_reg_we;
  reg_idx_t   ex_reg_addr;
  word_t      ex_reg_wdata;
  logic       ex_data_req;
  logic       ex_data_gnt;
  logic       ex_data_we;
  word_t      ex_data_addr;
  logic       wb_valid;
  logic       wb_reg_we;
  reg_idx_t   wb_reg_addr;
  word_t      wb_reg_wdata;
  logic       trace_valid;
  trace_rec_t trace;
  logic       issue_overflow;
  logic       ex_overflow;

  integer     seed;
  cycle_t     edge_cnt;
  trace_rec_t exp_q[$];
  trace_rec_t exp_rec;

  rv_trace_unit #(
    .ISSUE_DEPTH (ISSUE_DEPTH),
    .WB_DEPTH    (WB_DEPTH)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid       (id_valid),
    .is_decoding    (is_decoding),
    .pc             (pc),
    .instr          (instr),
    .ex_valid       (ex_valid),
    .wb_bypass      (wb_bypass),
    .ex_reg_we      (ex_reg_we),
    .ex_reg_addr    (ex_reg_addr),
    .ex_reg_wdata   (ex_reg_wdata),
    .ex_data_req    (ex_data_req),
    .ex_data_gnt    (ex_data_gnt),
    .ex_data_we     (ex_data_we),
    .ex_data_addr   (ex_data_addr),
    .wb_valid       (wb_valid),
    .wb_reg_we      (wb_reg_we),
    .wb_reg_addr    (wb_reg_addr),
    .wb_reg_wdata   (wb_reg_wdata),
    .trace_valid    (trace_valid),
    .trace          (trace),
    .issue_overflow (issue_overflow),
    .ex_overflow    (ex_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // rising edges since reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= '0;
    end else begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic instr_class_e ref_class(input logic [6:0] opc);
    instr_class_e c;
    case (opc)
      OPC_LUI:    c = cls_lui;
      OPC_AUIPC:  c = cls_auipc;
      OPC_JAL:    c = cls_jal;
      OPC_JALR:   c = cls_jalr;
      OPC_BRANCH: c = cls_branch;
      OPC_LOAD:   c = cls_load;
      OPC_STORE:  c = cls_store;
      OPC_OP_IMM: c = cls_op_imm;
      OPC_OP:     c = cls_op;
      OPC_SYSTEM: c = cls_system;
      OPC_FENCE:  c = cls_fence;
      default:    c = cls_invalid;
    endcase
    return c;
  endfunction

  // branch, store, fence and unknown never name a destination
  function automatic logic ref_writes(input instr_class_e c, input reg_idx_t rd);
    logic w;
    case (c)
      cls_branch, cls_store, cls_fence, cls_invalid: w = 1'b0;
      default:                                       w = 1'b1;
    endcase
    return w && (rd != 5'd0);
  endfunction

  function automatic trace_rec_t expected_base(input word_t ipc, input word_t iw,
                                               input cycle_t cyc);
    trace_rec_t r;
    r                 = '0;
    r.issue.pc        = ipc;
    r.issue.instr     = iw;
    r.issue.cycle     = cyc;
    r.issue.cls       = ref_class(iw[6:0]);
    r.issue.rd        = iw[11:7];
    r.issue.writes_rd = ref_writes(r.issue.cls, iw[11:7]);
    return r;
  endfunction

  function automatic word_t encode(input logic [6:0] opc, input reg_idx_t rd);
    return {12'h0a5, 5'd2, 3'b000, rd, opc};
  endfunction

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_record(input trace_rec_t e, input trace_rec_t g);
    check_field("trace.issue.pc", e.issue.pc, g.issue.pc);
    check_field("trace.issue.instr", e.issue.instr, g.issue.instr);
    check_field("trace.issue.cycle", e.issue.cycle, g.issue.cycle);
    check_field("trace.issue.cls", e.issue.cls, g.issue.cls);
    check_field("trace.issue.rd", e.issue.rd, g.issue.rd);
    check_field("trace.issue.writes_rd", e.issue.writes_rd, g.issue.writes_rd);
    check_field("trace.rd_written", e.rd_written, g.rd_written);
    check_field("trace.mem_valid", e.mem_valid, g.mem_valid);
    // value fields only mean something when their flag is set
    if (e.rd_written) begin
      check_field("trace.rd_value", e.rd_value, g.rd_value);
    end
    if (e.mem_valid) begin
      check_field("trace.mem_we", e.mem_we, g.mem_we);
      check_field("trace.mem_addr", e.mem_addr, g.mem_addr);
    end
  endtask

  // every retired record is matched against the oldest expected one
  always @(negedge clk) begin
    if (rst_n && trace_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected trace record at %0t, pc %h", $time, trace.issue.pc);
        $display("TB FAILED");
        $fatal(1);
      end else begin
        exp_rec = exp_q.pop_front();
        compare_record(exp_rec, trace);
      end
    end
  end

  ////////////////////////////////////////
  // drive helpers
  ////////////////////////////////////////

  task automatic clear_inputs();
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pc           = '0;
    instr        = '0;
    ex_valid     = 1'b0;
    wb_bypass    = 1'b0;
    ex_reg_we    = 1'b0;
    ex_reg_addr  = '0;
    ex_reg_wdata = '0;
    ex_data_req  = 1'b0;
    ex_data_gnt  = 1'b0;
    ex_data_we   = 1'b0;
    ex_data_addr = '0;
    wb_valid     = 1'b0;
    wb_reg_we    = 1'b0;
    wb_reg_addr  = '0;
    wb_reg_wdata = '0;
  endtask

  // strobes drop at the next falling edge
  task automatic step();
    @(negedge clk);
    clear_inputs();
  endtask

  task automatic issue_instr(input word_t ipc, input word_t iw, output trace_rec_t rec);
    id_valid    = 1'b1;
    is_decoding = 1'b1;
    pc          = ipc;
    instr       = iw;
    rec         = expected_base(ipc, iw, edge_cnt);
  endtask

  task automatic set_ex_wr(input reg_idx_t addr, input word_t data);
    ex_reg_we    = 1'b1;
    ex_reg_addr  = addr;
    ex_reg_wdata = data;
  endtask

  task automatic set_wb_wr(input reg_idx_t addr, input word_t data);
    wb_reg_we    = 1'b1;
    wb_reg_addr  = addr;
    wb_reg_wdata = data;
  endtask

  task automatic set_access(input logic we, input word_t addr);
    ex_data_req  = 1'b1;
    ex_data_gnt  = 1'b1;
    ex_data_we   = we;
    ex_data_addr = addr;
  endtask

  task automatic wait_drained();
    int cnt;
    cnt = 0;
    // polled on rising edges between monitor pops
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout with %0d trace records still not retired", exp_q.size());
      $display("TB FAILED");
      $fatal(1);
    end
    @(negedge clk);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic reset_and_stamp();
    trace_rec_t rec;
    word_t      v;
    check_field("trace_valid", 1'b0, trace_valid);
    check_field("issue_overflow", 1'b0, issue_overflow);
    check_field("ex_overflow", 1'b0, ex_overflow);
    // id_valid without is_decoding makes no record
    id_valid = 1'b1;
    instr    = encode(OPC_OP, 5'd1);
    step();
    step();
    step();
    v = $random(seed);
    issue_instr(32'h0000_0100, encode(OPC_OP, 5'd3), rec);
    rec.rd_written = 1'b1;
    rec.rd_value   = v;
    exp_q.push_back(rec);
    step();
    ex_valid = 1'b1;
    set_ex_wr(5'd3, v);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd3, v);
    step();
    wait_drained();
  endtask

  task automatic wb_write_match();
    trace_rec_t rec;
    word_t      va;
    word_t      vb;
    va = $random(seed);
    vb = $random(seed);
    issue_instr(32'h0000_0200, encode(OPC_OP_IMM, 5'd5), rec);
    rec.rd_written = 1'b1;
    rec.rd_value   = vb;
    exp_q.push_back(rec);
    step();
    ex_valid = 1'b1;
    set_ex_wr(5'd5, va);
    step();
    set_wb_wr(5'd7, va ^ vb);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd5, vb);
    step();
    wait_drained();
  endtask

  task automatic load_and_store();
    trace_rec_t rec;
    word_t      v;
    v = $random(seed);
    issue_instr(32'h0000_0300, encode(OPC_LOAD, 5'd9), rec);
    rec.rd_written = 1'b1;
    rec.rd_value   = v;
    rec.mem_valid  = 1'b1;
    rec.mem_we     = 1'b0;
    rec.mem_addr   = 32'h1000_0040;
    exp_q.push_back(rec);
    step();
    ex_valid = 1'b1;
    set_access(1'b0, 32'h1000_0040);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd9, v);
    step();
    // the first granted access of the store sticks
    // its rd field is part of the immediate
    issue_instr(32'h0000_0304, encode(OPC_STORE, 5'd4), rec);
    rec.mem_valid = 1'b1;
    rec.mem_we    = 1'b1;
    rec.mem_addr  = 32'h1000_0080;
    exp_q.push_back(rec);
    step();
    set_access(1'b1, 32'h1000_0080);
    step();
    ex_valid = 1'b1;
    set_access(1'b0, 32'h1000_00c0);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd4, v);
    step();
    wait_drained();
  endtask

  task automatic writes_suppressed();
    trace_rec_t rec;
    word_t      v;
    v = $random(seed);
    issue_instr(32'h0000_0400, encode(OPC_BRANCH, 5'd6), rec);
    exp_q.push_back(rec);
    step();
    wb_bypass = 1'b1;
    set_ex_wr(5'd6, v);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd6, v);
    step();
    issue_instr(32'h0000_0404, encode(OPC_OP_IMM, 5'd0), rec);
    exp_q.push_back(rec);
    step();
    ex_valid = 1'b1;
    set_ex_wr(5'd0, v);
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd0, v);
    step();
    issue_instr(32'h0000_0408, encode(7'b1111111, 5'd8), rec);
    exp_q.push_back(rec);
    step();
    ex_valid = 1'b1;
    step();
    wb_valid = 1'b1;
    set_wb_wr(5'd8, v);
    step();
    wait_drained();
  endtask

  task automatic staggered_retire();
    trace_rec_t rec;
    word_t      vals[3];
    for (int i = 0; i < 3; i++) begin
      vals[i] = $random(seed);
      issue_instr(32'h0000_0500 + word_t'(4 * i), encode(OPC_OP, reg_idx_t'(10 + i)), rec);
      rec.rd_written = 1'b1;
      rec.rd_value   = vals[i];
      exp_q.push_back(rec);
      step();
    end
    ex_valid = 1'b1;
    set_ex_wr(5'd10, vals[0]);
    step();
    ex_valid = 1'b1;
    wb_valid = 1'b1;
    set_ex_wr(5'd11, vals[1]);
    step();
    step();
    ex_valid = 1'b1;
    set_ex_wr(5'd12, vals[2]);
    step();
    wb_valid = 1'b1;
    step();
    wb_valid = 1'b1;
    step();
    wait_drained();
  endtask

  task automatic overflow_and_drain();
    trace_rec_t rec;
    // one issue more than the queue holds while nothing leaves EX
    for (int i = 0; i <= ISSUE_DEPTH; i++) begin
      issue_instr(32'h0000_0600 + word_t'(4 * i), encode(OPC_OP, reg_idx_t'(13 + i)), rec);
      if (i < ISSUE_DEPTH) begin
        exp_q.push_back(rec);
      end
      step();
    end
    check_field("issue_overflow", 1'b1, issue_overflow);
    for (int i = 0; i < ISSUE_DEPTH; i++) begin
      ex_valid = 1'b1;
      step();
      wb_valid = 1'b1;
      step();
    end
    wait_drained();
    // any record after the drain is flagged by the monitor
    repeat (4) step();
    check_field("ex_overflow", 1'b0, ex_overflow);
  endtask

  initial begin
    seed    = 32'hff57_b5dd;
    clear_inputs();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    reset_and_stamp();
    wb_write_match();
    load_and_store();
    writes_suppressed();
    staggered_retire();
    overflow_and_drain();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_trace_unit.f
common/trace_pkg.sv
hw/trace_fifo.sv
hw/issue_capture.sv
stage_track/ex_tracker.sv
stage_track/wb_tracker.sv
hw/rv_trace_unit.sv
testbench/tb_rv_trace_unit.sv

// File: Bender.yml
package:
  name: rv_trace_unit

sources:
  - files:
      - common/trace_pkg.sv
      - hw/trace_fifo.sv
      - hw/issue_capture.sv
      - stage_track/ex_tracker.sv
      - stage_track/wb_tracker.sv
      - hw/rv_trace_unit.sv
  - target: test
    files:
      - testbench/tb_rv_trace_unit.sv
